// ==== logic/fix_pkg.sv ====
package fix_pkg;

	localparam int DATA_W = 16;
	localparam int TYPE_W = 3;
	localparam int SEQ_W  = DATA_W - TYPE_W;	// 13 bit sequence field
	localparam int AXI_DW = 32;

	typedef enum logic [TYPE_W-1:0] {
		MSG_LOGON     = 3'b001,
		MSG_HEARTBEAT = 3'b010,
		MSG_LOGOUT    = 3'b100,
		MSG_BUSINESS  = 3'b111
	} msg_type_e;

	typedef enum logic [2:0] {
		RX_INVALID = 3'b000,
		RX_VALID   = 3'b001
	} rx_status_e;

	typedef enum logic [2:0] {
		S_WAIT_CFG,
		S_WAIT_START,
		S_CONNECTING,
		S_BUILDING,
		S_AWAIT_LOGON,
		S_ACTIVE,
		S_AWAIT_HB,
		S_DISCONNECTING
	} session_state_e;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              last;	// final word of a frame
	} frame_word_t;

	typedef struct packed {
		msg_type_e  msg_type;
		rx_status_e status;
	} rx_msg_t;

	localparam logic [3:0] REG_COMPID  = 4'h0;
	localparam logic [3:0] REG_TIMEOUT = 4'h4;
	localparam logic [3:0] REG_CTRL    = 4'h8;	// bit0 start, bit1 end, bit2 business
	localparam logic [3:0] REG_STATUS  = 4'hC;

endpackage

// ==== logic/fix_cfg_regs.sv ====
`timescale 1ns/1ps

module fix_cfg_regs import fix_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic [3:0]        awaddr_i,
	input  logic              awvalid_i,
	output logic              awready_o,
	input  logic [AXI_DW-1:0] wdata_i,
	input  logic              wvalid_i,
	output logic              wready_o,
	output logic              bvalid_o,
	input  logic              bready_i,
	output logic [1:0]        bresp_o,
	input  logic [3:0]        araddr_i,
	input  logic              arvalid_i,
	output logic              arready_o,
	output logic [AXI_DW-1:0] rdata_o,
	output logic              rvalid_o,
	input  logic              rready_i,
	output logic [1:0]        rresp_o,
	input  session_state_e    state_i,
	input  logic [SEQ_W-1:0]  seq_i,
	output logic [DATA_W-1:0] comp_id_o,
	output logic [15:0]       timeout_o,
	output logic              cfg_loaded_o,
	output logic              start_o,
	output logic              end_session_o,
	output logic              send_business_o
);

	logic              aw_seen;
	logic              w_seen;
	logic [3:0]        aw_addr;
	logic [AXI_DW-1:0] w_data;

	assign awready_o = !aw_seen && !bvalid_o;	// one write in flight
	assign wready_o  = !w_seen && !bvalid_o;
	assign arready_o = !rvalid_o;
	assign bresp_o   = 2'b00;
	assign rresp_o   = 2'b00;

	always_ff @(posedge clk) begin
		if (awvalid_i && awready_o)
			aw_addr <= awaddr_i;
		if (wvalid_i && wready_o)
			w_data <= wdata_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_seen         <= 1'b0;
			w_seen          <= 1'b0;
			bvalid_o        <= 1'b0;
			rvalid_o        <= 1'b0;
			rdata_o         <= '0;
			comp_id_o       <= '0;
			timeout_o       <= '0;
			cfg_loaded_o    <= 1'b0;
			start_o         <= 1'b0;
			end_session_o   <= 1'b0;
			send_business_o <= 1'b0;
		end else begin
			cfg_loaded_o    <= 1'b0;
			start_o         <= 1'b0;
			end_session_o   <= 1'b0;
			send_business_o <= 1'b0;
			if (awvalid_i && awready_o)
				aw_seen <= 1'b1;
			if (wvalid_i && wready_o)
				w_seen <= 1'b1;
			if (aw_seen && w_seen) begin	// address and data both in hand
				aw_seen  <= 1'b0;
				w_seen   <= 1'b0;
				bvalid_o <= 1'b1;
				case (aw_addr)
					REG_COMPID: begin
						comp_id_o    <= w_data[DATA_W-1:0];
						cfg_loaded_o <= 1'b1;
					end
					REG_TIMEOUT: timeout_o <= w_data[15:0];
					REG_CTRL: begin
						start_o         <= w_data[0];
						end_session_o   <= w_data[1];
						send_business_o <= w_data[2];
					end
					default: ;	// status is read only
				endcase
			end
			if (bvalid_o && bready_i)
				bvalid_o <= 1'b0;
			if (arvalid_i && arready_o) begin
				rvalid_o <= 1'b1;
				case (araddr_i)
					REG_COMPID:  rdata_o <= {16'b0, comp_id_o};
					REG_TIMEOUT: rdata_o <= {16'b0, timeout_o};
					REG_STATUS:  rdata_o <= {16'b0, seq_i, state_i};
					default:     rdata_o <= '0;
				endcase
			end else if (rvalid_o && rready_i) begin
				rvalid_o <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/fix_session_ctrl.sv ====
`timescale 1ns/1ps

module fix_session_ctrl import fix_pkg::*; (
	input  logic           clk,
	input  logic           rst,
	input  logic           cfg_loaded_i,
	input  logic           start_i,
	input  logic           end_session_i,
	input  logic           send_business_i,
	input  logic [15:0]    timeout_i,
	input  logic           connected_i,
	input  logic           rx_valid_i,
	input  rx_msg_t        rx_msg_i,
	input  logic           frame_done_i,
	input  logic           build_busy_i,
	output logic           connect_o,
	output logic           disconnect_o,
	output logic           build_req_o,
	output msg_type_e      build_type_o,
	output session_state_e state_o
);

	session_state_e state;
	msg_type_e      kind;		// frame being built
	logic [15:0]    timer;
	logic           req_pend;
	logic           biz_pend;
	logic           end_pend;
	logic           session_up;

	assign session_up   = (state == S_BUILDING) || (state == S_AWAIT_LOGON) ||
	                      (state == S_ACTIVE) || (state == S_AWAIT_HB);
	assign build_req_o  = req_pend && !build_busy_i;
	assign build_type_o = kind;
	assign state_o      = state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= S_WAIT_CFG;
			kind         <= MSG_LOGON;
			timer        <= '0;
			req_pend     <= 1'b0;
			biz_pend     <= 1'b0;
			end_pend     <= 1'b0;
			connect_o    <= 1'b0;
			disconnect_o <= 1'b0;
		end else begin
			connect_o    <= 1'b0;
			disconnect_o <= 1'b0;
			if (build_req_o)
				req_pend <= 1'b0;
			case (state)
				S_WAIT_CFG: if (cfg_loaded_i) state <= S_WAIT_START;
				S_WAIT_START: begin
					if (start_i) begin
						connect_o <= 1'b1;	// ask the link to open
						state     <= S_CONNECTING;
					end
				end
				S_CONNECTING: begin
					if (connected_i) begin
						kind     <= MSG_LOGON;
						req_pend <= 1'b1;
						state    <= S_BUILDING;
					end
				end
				S_BUILDING: begin
					if (frame_done_i) begin
						timer <= '0;
						case (kind)
							MSG_LOGON:     state <= S_AWAIT_LOGON;
							MSG_HEARTBEAT: state <= S_AWAIT_HB;
							MSG_LOGOUT:    state <= S_DISCONNECTING;
							default:       state <= S_ACTIVE;	// business
						endcase
					end
				end
				S_AWAIT_LOGON: begin
					timer <= timer + 16'd1;
					if (rx_valid_i && rx_msg_i.status == RX_VALID)
						state <= S_ACTIVE;
					else if (rx_valid_i || timer == timeout_i)
						state <= S_DISCONNECTING;	// bad reply or no reply
				end
				S_ACTIVE: begin
					if (biz_pend) begin
						kind     <= MSG_BUSINESS;
						biz_pend <= 1'b0;
						req_pend <= 1'b1;
						state    <= S_BUILDING;
					end else if (end_pend ||
					             (rx_valid_i && rx_msg_i.msg_type == MSG_LOGOUT)) begin
						kind     <= MSG_LOGOUT;
						end_pend <= 1'b0;
						req_pend <= 1'b1;
						state    <= S_BUILDING;
					end else if (rx_valid_i && rx_msg_i.msg_type == MSG_HEARTBEAT) begin
						kind     <= MSG_HEARTBEAT;	// answer the peer
						req_pend <= 1'b1;
						state    <= S_BUILDING;
					end
				end
				S_AWAIT_HB: begin
					timer <= timer + 16'd1;
					if (rx_valid_i && rx_msg_i.status == RX_VALID) begin
						state <= S_ACTIVE;
					end else if (rx_valid_i || timer == timeout_i) begin
						kind     <= MSG_LOGOUT;	// peer lost, log out cleanly
						req_pend <= 1'b1;
						state    <= S_BUILDING;
					end
				end
				S_DISCONNECTING: begin
					disconnect_o <= 1'b1;
					biz_pend     <= 1'b0;
					end_pend     <= 1'b0;
					state        <= S_WAIT_CFG;
				end
				default: state <= S_WAIT_CFG;
			endcase
			// requests arriving mid-frame are held until active
			if (session_up && send_business_i)
				biz_pend <= 1'b1;
			if (session_up && end_session_i)
				end_pend <= 1'b1;
		end
	end

endmodule

// ==== logic/fix_frame_builder.sv ====
`timescale 1ns/1ps

module fix_frame_builder import fix_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              build_req_i,
	input  msg_type_e         build_type_i,
	input  logic [DATA_W-1:0] comp_id_i,
	input  logic              full_i,
	output logic              push_o,
	output frame_word_t       push_word_o,
	output logic              frame_done_o,
	output logic              build_busy_o,
	output logic [SEQ_W-1:0]  seq_o
);

	logic              busy;
	logic [1:0]        idx;		// word within frame
	msg_type_e         type_r;
	logic [SEQ_W-1:0]  seq;
	logic [DATA_W-1:0] csum;
	logic [DATA_W-1:0] word;

	always_comb begin
		case (idx)
			2'd0:    word = {type_r, seq};
			2'd1:    word = comp_id_i;
			default: word = csum;
		endcase
	end

	assign push_o           = busy && !full_i;	// stall on full FIFO
	assign push_word_o.data = word;
	assign push_word_o.last = (idx == 2'd2);
	assign build_busy_o     = busy;
	assign seq_o            = seq;

	always_ff @(posedge clk) begin
		if (build_req_i && !busy)
			type_r <= build_type_i;
		if (push_o)
			csum <= (idx == 2'd0) ? word : csum + word;	// mod 2^16 sum
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy         <= 1'b0;
			idx          <= '0;
			seq          <= SEQ_W'(1);
			frame_done_o <= 1'b0;
		end else begin
			frame_done_o <= 1'b0;
			if (build_req_i && !busy) begin
				busy <= 1'b1;
				idx  <= '0;
			end else if (push_o) begin
				if (idx == 2'd2) begin
					busy         <= 1'b0;
					frame_done_o <= 1'b1;
					seq          <= seq + SEQ_W'(1);
				end
				idx <= idx + 2'd1;
			end
		end
	end

endmodule

// ==== logic/fix_tx_fifo.sv ====
`timescale 1ns/1ps

module fix_tx_fifo import fix_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        push_i,
	input  frame_word_t push_word_i,
	input  logic        pop_i,
	output frame_word_t head_o,
	output logic        full_o,
	output logic        empty_o
);

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	frame_word_t   mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	assign full_o  = (count == CW'(FIFO_DEPTH));
	assign empty_o = (count == '0);
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;
	assign head_o  = mem[rd_ptr];	// show-ahead

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_word_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
			if (do_push && !do_pop)
				count <= count + CW'(1);
			else if (do_pop && !do_push)
				count <= count - CW'(1);
		end
	end

endmodule

// ==== logic/fix_tx_link.sv ====
`timescale 1ns/1ps

module fix_tx_link import fix_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  frame_word_t       head_i,
	input  logic              empty_i,
	input  logic              tx_ready_i,
	output logic              pop_o,
	output logic [DATA_W-1:0] tx_data_o,
	output logic              tx_last_o,
	output logic              tx_valid_o,
	output logic [15:0]       frames_sent_o
);

	// head only moves on a pop, so data holds while ready is low
	assign tx_valid_o = !empty_i;
	assign tx_data_o  = head_i.data;
	assign tx_last_o  = head_i.last;
	assign pop_o      = tx_valid_o && tx_ready_i;

	always_ff @(posedge clk) begin
		if (rst)
			frames_sent_o <= '0;
		else if (pop_o && head_i.last)
			frames_sent_o <= frames_sent_o + 16'd1;	// whole frame gone
	end

endmodule

// ==== logic/fix_engine_top.sv ====
`timescale 1ns/1ps

module fix_engine_top import fix_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [3:0]        awaddr_i,
	input  logic              awvalid_i,
	output logic              awready_o,
	input  logic [AXI_DW-1:0] wdata_i,
	input  logic              wvalid_i,
	output logic              wready_o,
	output logic              bvalid_o,
	input  logic              bready_i,
	output logic [1:0]        bresp_o,
	input  logic [3:0]        araddr_i,
	input  logic              arvalid_i,
	output logic              arready_o,
	output logic [AXI_DW-1:0] rdata_o,
	output logic              rvalid_o,
	input  logic              rready_i,
	output logic [1:0]        rresp_o,
	input  logic              connected_i,
	input  logic              rx_valid_i,
	input  rx_msg_t           rx_msg_i,
	input  logic              tx_ready_i,
	output logic              connect_o,
	output logic              disconnect_o,
	output logic [DATA_W-1:0] tx_data_o,
	output logic              tx_last_o,
	output logic              tx_valid_o,
	output logic [15:0]       frames_sent_o
);

	logic [DATA_W-1:0] comp_id;
	logic [15:0]       timeout_cycles;
	logic              cfg_loaded;
	logic              start;
	logic              end_session;
	logic              send_business;
	session_state_e    state;
	logic [SEQ_W-1:0]  seq;
	logic              build_req;
	msg_type_e         build_type;
	logic              build_busy;
	logic              frame_done;
	logic              push;
	frame_word_t       push_word;
	logic              full;
	logic              empty;
	frame_word_t       head;
	logic              pop;

	fix_cfg_regs regs0 (
		.clk(clk), .rst(rst),
		.awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
		.wdata_i(wdata_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
		.bvalid_o(bvalid_o), .bready_i(bready_i), .bresp_o(bresp_o),
		.araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
		.rdata_o(rdata_o), .rvalid_o(rvalid_o), .rready_i(rready_i), .rresp_o(rresp_o),
		.state_i(state), .seq_i(seq),
		.comp_id_o(comp_id), .timeout_o(timeout_cycles),
		.cfg_loaded_o(cfg_loaded), .start_o(start),
		.end_session_o(end_session), .send_business_o(send_business)
	);

	fix_session_ctrl ctrl0 (
		.clk(clk), .rst(rst),
		.cfg_loaded_i(cfg_loaded), .start_i(start),
		.end_session_i(end_session), .send_business_i(send_business),
		.timeout_i(timeout_cycles), .connected_i(connected_i),
		.rx_valid_i(rx_valid_i), .rx_msg_i(rx_msg_i),
		.frame_done_i(frame_done), .build_busy_i(build_busy),
		.connect_o(connect_o), .disconnect_o(disconnect_o),
		.build_req_o(build_req), .build_type_o(build_type), .state_o(state)
	);

	fix_frame_builder builder0 (
		.clk(clk), .rst(rst),
		.build_req_i(build_req), .build_type_i(build_type),
		.comp_id_i(comp_id), .full_i(full),
		.push_o(push), .push_word_o(push_word),
		.frame_done_o(frame_done), .build_busy_o(build_busy), .seq_o(seq)
	);

	fix_tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
		.clk(clk), .rst(rst),
		.push_i(push), .push_word_i(push_word), .pop_i(pop),
		.head_o(head), .full_o(full), .empty_o(empty)
	);

	fix_tx_link link0 (
		.clk(clk), .rst(rst),
		.head_i(head), .empty_i(empty), .tx_ready_i(tx_ready_i),
		.pop_o(pop), .tx_data_o(tx_data_o), .tx_last_o(tx_last_o),
		.tx_valid_o(tx_valid_o), .frames_sent_o(frames_sent_o)
	);

endmodule

// ==== verif/fix_engine_tb.sv ====
`timescale 1ns/1ps

module fix_engine_tb import fix_pkg::*; ();

	logic clk, rst;
	logic [3:0] awaddr_i, araddr_i;
	logic awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
	logic [31:0] wdata_i;
	logic awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
	logic [1:0] bresp_o, rresp_o;
	logic [31:0] rdata_o;
	logic connected_i, rx_valid_i, tx_ready_i;
	rx_msg_t rx_msg_i;
	logic connect_o, disconnect_o, tx_last_o, tx_valid_o;
	logic [15:0] tx_data_o, frames_sent_o;

	logic [16:0] words[$];	// accepted {data, last}
	logic [16:0] prev_word;
	logic        prev_stall;
	logic [15:0] comp_exp;
	int errors, frames_seen, frames_checked, conn_cnt, conn_used, disc_cnt, disc_used;
	int cycles, limit;

	fix_engine_top #(.FIFO_DEPTH(8)) dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin : ready_driver
		int seed;
		seed = $urandom(32'h67bdc9a7);
		tx_ready_i = 1'b0;
		forever begin
			@(posedge clk);
			#2 tx_ready_i = $urandom % 2;	// random back-pressure
		end
	end

	// stream monitor and link pulse counters
	always @(posedge clk) begin
		if (rst) begin
			prev_stall <= 1'b0;
		end else begin
			if (prev_stall)
				assert (tx_valid_o && {tx_data_o, tx_last_o} == prev_word) else begin
					errors++;
					$display("ERR t=%0t tx_data_o/tx_last_o moved while stalled exp %h got %h",
						$time, prev_word, {tx_data_o, tx_last_o});
				end
			if (tx_valid_o && tx_ready_i) begin
				words.push_back({tx_data_o, tx_last_o});
				if (tx_last_o)
					frames_seen++;
			end
			if (connect_o)
				conn_cnt++;
			if (disconnect_o)
				disc_cnt++;
			prev_stall <= tx_valid_o && !tx_ready_i;
			prev_word  <= {tx_data_o, tx_last_o};
		end
	end

	initial begin : watchdog
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: vectors did not finish within %0d cycles, errors %0d", limit, errors);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
		logic aw_done, w_done, b_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		b_done = 1'b0;
		awaddr_i = addr;
		wdata_i = data;
		awvalid_i = 1'b1;
		wvalid_i = 1'b1;
		bready_i = 1'b1;
		while (!(aw_done && w_done)) begin
			@(posedge clk);
			if (awready_o)
				aw_done = 1'b1;
			if (wready_o)
				w_done = 1'b1;
			#2;
			awvalid_i = !aw_done;
			wvalid_i = !w_done;
		end
		while (!b_done) begin
			@(posedge clk);
			b_done = bvalid_o;
			if (b_done)
				assert (bresp_o == 2'b00) else begin
					errors++;
					$display("ERR t=%0t bresp_o exp 0 got %0d", $time, bresp_o);
				end
			#2;
		end
		bready_i = 1'b0;
		if (addr == REG_COMPID)
			comp_exp = data[15:0];
	endtask

	task automatic axi_read_check(input logic [3:0] addr, input logic [31:0] exp);
		logic got_ar, got_r;
		logic [31:0] data;
		logic [1:0] resp;
		got_ar = 1'b0;
		got_r = 1'b0;
		araddr_i = addr;
		arvalid_i = 1'b1;
		rready_i = 1'b1;
		while (!got_ar) begin
			@(posedge clk);
			got_ar = arready_o;
			#2;
		end
		arvalid_i = 1'b0;
		while (!got_r) begin
			@(posedge clk);
			got_r = rvalid_o;
			data = rdata_o;
			resp = rresp_o;
			#2;
		end
		rready_i = 1'b0;
		assert (data == exp) else begin
			errors++;
			$display("ERR t=%0t rdata_o[%h] exp %h got %h", $time, addr, exp, data);
		end
		assert (resp == 2'b00) else begin
			errors++;
			$display("ERR t=%0t rresp_o exp 0 got %0d", $time, resp);
		end
	endtask

	task automatic frame_check(input logic [2:0] kind, input logic [12:0] seq);
		logic [16:0] exp[3];
		logic [16:0] got;
		exp[0] = {kind, seq, 1'b0};
		exp[1] = {comp_exp, 1'b0};
		exp[2] = {exp[0][16:1] + exp[1][16:1], 1'b1};	// checksum mod 2^16
		while (words.size() < 3)
			next_cycle();
		for (int i = 0; i < 3; i++) begin
			got = words.pop_front();
			assert (got == exp[i]) else begin
				errors++;
				$display("ERR t=%0t tx_data_o/tx_last_o word %0d exp %h got %h",
					$time, i, exp[i], got);
			end
		end
		frames_checked++;
		assert (frames_sent_o == frames_seen) else begin
			errors++;
			$display("ERR t=%0t frames_sent_o exp %0d got %0d", $time, frames_seen, frames_sent_o);
		end
	endtask

	initial begin : main
		int fd, code, n_lines;
		string line;
		logic [7:0] cmd;
		logic [31:0] a, b;
		rst = 1'b1;
		awaddr_i = '0;
		araddr_i = '0;
		awvalid_i = 1'b0;
		wvalid_i = 1'b0;
		wdata_i = '0;
		bready_i = 1'b0;
		arvalid_i = 1'b0;
		rready_i = 1'b0;
		connected_i = 1'b0;
		rx_valid_i = 1'b0;
		rx_msg_i = '0;
		comp_exp = '0;
		n_lines = 0;
		fd = $fopen("verif/fix_engine_vectors.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the vector file");
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0)
					n_lines++;
			end
			$fclose(fd);
			fd = $fopen("verif/fix_engine_vectors.txt", "r");
			limit = 200 * n_lines + 20;
		end
		repeat (10) @(posedge clk);
		#2 rst = 1'b0;
		if (fd != 0) begin
			while ($fscanf(fd, " %c", cmd) == 1) begin
				case (cmd)
					"#": code = $fgets(line, fd);
					"W": begin
						code = $fscanf(fd, "%h %h", a, b);
						axi_write(a[3:0], b);
					end
					"R": begin
						code = $fscanf(fd, "%h %h", a, b);
						axi_read_check(a[3:0], b);
					end
					"C": begin
						while (conn_cnt <= conn_used)
							next_cycle();
						conn_used++;
						connected_i = 1'b1;
					end
					"X": begin
						code = $fscanf(fd, "%h %h", a, b);
						rx_msg_i.msg_type = msg_type_e'(a[2:0]);
						rx_msg_i.status = rx_status_e'(b[2:0]);
						rx_valid_i = 1'b1;
						next_cycle();
						rx_valid_i = 1'b0;
					end
					"F": begin
						code = $fscanf(fd, "%h %h", a, b);
						frame_check(a[2:0], b[12:0]);
					end
					"D": begin
						while (disc_cnt <= disc_used)
							next_cycle();
						disc_used++;
						connected_i = 1'b0;	// link drops with the session
					end
					"Q": begin
						code = $fscanf(fd, "%h", a);
						repeat (a) next_cycle();
						assert (words.size() == 0) else begin
							errors++;
							$display("a frame word appeared on the stream after the disconnect");
						end
					end
					default: begin
						errors++;
						$display("unknown command in the vector file: %c", cmd);
					end
				endcase
			end
			$fclose(fd);
		end
		assert (disc_cnt == disc_used && conn_cnt == conn_used) else begin
			errors++;
			$display("unexpected connect or disconnect pulse seen");
		end
		$display("frames checked %0d, errors %0d", frames_checked, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== compile.f ====
logic/fix_pkg.sv
logic/fix_cfg_regs.sv
logic/fix_session_ctrl.sv
logic/fix_frame_builder.sv
logic/fix_tx_fifo.sv
logic/fix_tx_link.sv
logic/fix_engine_top.sv
verif/fix_engine_tb.sv

// ==== verif/fix_engine_vectors.txt ====
# W addr data | R addr expected rdata | C (await connect_o, raise connected_i)
# X type status (rx pulse) | F type seq (expected frame) | D (await disconnect_o) | Q cycles
W 0 5a3c
W 4 0080
R 0 5a3c
R 4 0080
R c 0009
W 8 0001
C
F 1 0001
X 1 1
W 8 0004
W 8 0004
F 7 0002
F 7 0003
X 2 1
F 2 0004
X 2 1
R c 002d
W 8 0002
F 4 0005
D
R c 0030
W 0 1234
W 8 0001
C
F 1 0006
D
Q 0040
R c 0038
